//--- procPkg.sv
package procPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int dataWidth    = 32;
    localparam int instrWidth   = 32;
    localparam int regAddrWidth = 6;
    localparam int regCount     = 2 ** regAddrWidth;   // 64 registers
    localparam int functWidth   = 4;
    localparam int immWidth     = 15;
    localparam int pcWidth      = 6;                   // wraps after 64 fetches
    localparam int memDepth     = 128;
    localparam int memAddrWidth = 7;                   // low bits of alu address

    // funct = {opsel[2:0], mode}
    // arithmetic ops, mode 0
    localparam logic [functWidth-1:0] opAdd    = 4'b0000;
    localparam logic [functWidth-1:0] opSub    = 4'b0010;
    localparam logic [functWidth-1:0] opMove   = 4'b0100;
    localparam logic [functWidth-1:0] opAddInc = 4'b0110;
    localparam logic [functWidth-1:0] opInc    = 4'b1000;
    localparam logic [functWidth-1:0] opDec    = 4'b1010;

    // logic ops, mode 1
    localparam logic [functWidth-1:0] opAnd    = 4'b0001;
    localparam logic [functWidth-1:0] opOr     = 4'b0011;
    localparam logic [functWidth-1:0] opXor    = 4'b0101;
    localparam logic [functWidth-1:0] opNot    = 4'b0111;
    localparam logic [functWidth-1:0] opShl    = 4'b1001;
    localparam logic [functWidth-1:0] opLoad   = 4'b1011;
    localparam logic [functWidth-1:0] opStore  = 4'b1101;

    ////////////////////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////////////////////

    // register format, bits 31:23 carry nothing
    typedef struct packed {
        logic [8:0]              spare;
        logic [regAddrWidth-1:0] rt;      // 22:17
        logic [functWidth-1:0]   funct;   // 16:13
        logic [regAddrWidth-1:0] rd;      // 12:7
        logic [regAddrWidth-1:0] rs;      // 6:1
        logic                    isImm;   // 0
    } rFormat_t;

    // immediate format, signed imm in 31:17
    typedef struct packed {
        logic [immWidth-1:0]     imm;
        logic [functWidth-1:0]   funct;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic                    isImm;
    } iFormat_t;

    // same word, read as either format depending on bit 0
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instr_t;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  procPkg::instr_t                    instr,
    output logic [procPkg::regAddrWidth-1:0]   readAddr1,
    output logic [procPkg::regAddrWidth-1:0]   readAddr2,
    output logic [procPkg::regAddrWidth-1:0]   destAddr,
    output logic [procPkg::functWidth-1:0]     aluOp,
    output logic [procPkg::dataWidth-1:0]      immExt,
    output logic                               useImm,
    output logic                               regWrite,
    output logic                               memWrite,
    output logic                               isLoad
);

    logic isStoreCode;

    // fields common to both formats sit in the same place
    assign readAddr1 = instr.r.rs;
    assign destAddr  = instr.r.rd;
    assign aluOp     = instr.r.funct;
    assign useImm    = instr.r.isImm;

    assign immExt = {{(procPkg::dataWidth - procPkg::immWidth){instr.i.imm[procPkg::immWidth-1]}},
                     instr.i.imm};

    // store data comes from rd
    assign readAddr2 = isStoreCode ? instr.r.rd : instr.r.rt;

    always_comb begin
        regWrite    = 1'b0;
        memWrite    = 1'b0;
        isLoad      = 1'b0;
        isStoreCode = 1'b0;
        case (instr.r.funct)
            procPkg::opAdd, procPkg::opSub, procPkg::opMove, procPkg::opAddInc,
            procPkg::opInc, procPkg::opDec, procPkg::opAnd, procPkg::opOr,
            procPkg::opXor, procPkg::opNot, procPkg::opShl: begin
                regWrite = 1'b1;
            end
            procPkg::opLoad: begin
                regWrite = instr.i.isImm;   // R-format load is a nop
                isLoad   = instr.i.isImm;
            end
            procPkg::opStore: begin
                isStoreCode = 1'b1;
                memWrite    = instr.i.isImm;
            end
            default: begin
                regWrite = 1'b0;            // unused code, nothing enabled
            end
        endcase
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                               clk,
    input  logic                               clkreset,
    input  logic [procPkg::regAddrWidth-1:0]   readAddr1,
    input  logic [procPkg::regAddrWidth-1:0]   readAddr2,
    input  logic [procPkg::regAddrWidth-1:0]   writeAddr,
    input  logic                               writeEnable,
    input  logic [procPkg::dataWidth-1:0]      writeData,
    output logic [procPkg::dataWidth-1:0]      readData1,
    output logic [procPkg::dataWidth-1:0]      readData2
);

    logic [procPkg::dataWidth-1:0] regs [procPkg::regCount];

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            for (int idx = 0; idx < procPkg::regCount; idx++) begin
                regs[idx] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;   // r0 stays zero
        end
    end

    // read before write, same-cycle write not forwarded
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

//--- aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [procPkg::dataWidth-1:0]  operandA,
    input  logic [procPkg::dataWidth-1:0]  operandB,
    input  logic [procPkg::functWidth-1:0] aluOp,
    output logic [procPkg::dataWidth-1:0]  result
);

    ////////////////////////////////////////////////////////////////////////////
    // arithmetic ops (mode 0)
    ////////////////////////////////////////////////////////////////////////////

    logic [procPkg::dataWidth-1:0] arithResult;

    always_comb begin
        case (aluOp)
            procPkg::opAdd:    arithResult = operandA + operandB;
            procPkg::opSub:    arithResult = operandA - operandB;
            procPkg::opMove:   arithResult = operandA;
            procPkg::opAddInc: arithResult = operandA + operandB + 1'b1;
            procPkg::opInc:    arithResult = operandA + 1'b1;
            procPkg::opDec:    arithResult = operandA - 1'b1;
            default:           arithResult = '0;   // unused even codes
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // logic ops (mode 1)
    ////////////////////////////////////////////////////////////////////////////

    logic [procPkg::dataWidth-1:0] logicResult;

    always_comb begin
        case (aluOp)
            procPkg::opAnd:   logicResult = operandA & operandB;
            procPkg::opOr:    logicResult = operandA | operandB;
            procPkg::opXor:   logicResult = operandA ^ operandB;
            procPkg::opNot:   logicResult = ~operandA;
            procPkg::opShl:   logicResult = operandA << 1;
            // memory ops only need the address
            procPkg::opLoad,
            procPkg::opStore: logicResult = operandA + operandB;
            default:          logicResult = '0;
        endcase
    end

    // mode bit picks the half
    assign result = aluOp[0] ? logicResult : arithResult;

endmodule

//--- dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic                               clk,
    input  logic                               clkreset,
    input  logic [procPkg::memAddrWidth-1:0]   address,
    input  logic                               writeEnable,
    input  logic [procPkg::dataWidth-1:0]      writeData,
    output logic [procPkg::dataWidth-1:0]      readData
);

    logic [procPkg::dataWidth-1:0] mem [procPkg::memDepth];

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            for (int idx = 0; idx < procPkg::memDepth; idx++) begin
                mem[idx] <= '0;
            end
        end else if (writeEnable) begin
            mem[address] <= writeData;
        end
    end

    assign readData = mem[address];   // async read

endmodule

//--- procCore.sv
`timescale 1ns/1ps

module procCore (
    input  logic                               clk,
    input  logic                               clkreset,
    input  logic [procPkg::instrWidth-1:0]     instr,
    output logic [procPkg::pcWidth-1:0]        fetchAddr,
    output logic                               retireValid,
    output logic [procPkg::regAddrWidth-1:0]   retireDest,
    output logic [procPkg::dataWidth-1:0]      retireData
);

    logic [procPkg::pcWidth-1:0]      pc;

    logic [procPkg::regAddrWidth-1:0] readAddr1;
    logic [procPkg::regAddrWidth-1:0] readAddr2;
    logic [procPkg::regAddrWidth-1:0] destAddr;
    logic [procPkg::functWidth-1:0]   aluOp;
    logic [procPkg::dataWidth-1:0]    immExt;
    logic                             useImm;
    logic                             regWrite;
    logic                             memWrite;
    logic                             isLoad;

    logic [procPkg::dataWidth-1:0]    readData1;
    logic [procPkg::dataWidth-1:0]    readData2;
    logic [procPkg::dataWidth-1:0]    operandB;
    logic [procPkg::dataWidth-1:0]    aluResult;
    logic [procPkg::dataWidth-1:0]    memReadData;
    logic [procPkg::dataWidth-1:0]    writeBack;
    logic                             retireNext;

    ////////////////////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            pc <= '0;
        end else begin
            pc <= pc + 1'b1;   // 63 rolls over to 0
        end
    end

    assign fetchAddr = pc;

    ////////////////////////////////////////////////////////////////////////////
    // decode, execute, memory
    ////////////////////////////////////////////////////////////////////////////

    instrDecoder decoder (
        .instr     (instr),
        .readAddr1 (readAddr1),
        .readAddr2 (readAddr2),
        .destAddr  (destAddr),
        .aluOp     (aluOp),
        .immExt    (immExt),
        .useImm    (useImm),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .isLoad    (isLoad)
    );

    regFile registers (
        .clk         (clk),
        .clkreset    (clkreset),
        .readAddr1   (readAddr1),
        .readAddr2   (readAddr2),
        .writeAddr   (destAddr),
        .writeEnable (regWrite),
        .writeData   (writeBack),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    assign operandB = useImm ? immExt : readData2;

    aluUnit alu (
        .operandA (readData1),
        .operandB (operandB),
        .aluOp    (aluOp),
        .result   (aluResult)
    );

    // store data is rd, fetched on read port 2
    dataMem memory (
        .clk         (clk),
        .clkreset    (clkreset),
        .address     (aluResult[procPkg::memAddrWidth-1:0]),
        .writeEnable (memWrite),
        .writeData   (readData2),
        .readData    (memReadData)
    );

    assign writeBack = isLoad ? memReadData : aluResult;

    ////////////////////////////////////////////////////////////////////////////
    // retire
    ////////////////////////////////////////////////////////////////////////////

    assign retireNext = regWrite && (destAddr != '0);

    always_ff @(posedge clk) begin
        if (!clkreset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= retireNext;
        end
    end

    always_ff @(posedge clk) begin
        if (retireNext) begin
            retireDest <= destAddr;
            retireData <= writeBack;
        end
    end

endmodule

//--- procCore_checker.sv
`timescale 1ns/1ps

module procCore_checker (
    input logic                               clk,
    input logic                               clkreset,
    input logic [procPkg::pcWidth-1:0]        fetchAddr,
    input logic                               retireValid,
    input logic [procPkg::regAddrWidth-1:0]   retireDest
);

    // retire register is cleared by the reset edge
    property quietInReset;
        @(posedge clk) !clkreset |=> !retireValid;
    endproperty

    // r0 writes are dropped, so they never retire
    property destNeverZero;
        @(posedge clk) disable iff (!clkreset) retireValid |-> (retireDest != '0);
    endproperty

    property pcSteps;
        @(posedge clk) disable iff (!clkreset)
            clkreset |=> (fetchAddr == $past(fetchAddr) + 1'b1);   // 6 bits, wraps at 63
    endproperty

    assert property (quietInReset)
        else $error("retireValid high while the core is held in reset");
    assert property (destNeverZero)
        else $error("retire reported with destination register 0");
    assert property (pcSteps)
        else $error("fetchAddr did not advance by one");

endmodule

bind procCore procCore_checker coreChecker (
    .clk         (clk),
    .clkreset    (clkreset),
    .fetchAddr   (fetchAddr),
    .retireValid (retireValid),
    .retireDest  (retireDest)
);

//--- procTb.sv
`timescale 1ns/1ps

module procTb;

    localparam int runLength = 256;   // four passes over the program
    localparam int maxCycles = 1000;
    localparam int progDepth = 2 ** procPkg::pcWidth;

    logic                              clk = 1'b0;
    logic                              clkreset;
    logic [procPkg::instrWidth-1:0]    instr;
    logic [procPkg::pcWidth-1:0]       fetchAddr;
    logic                              retireValid;
    logic [procPkg::regAddrWidth-1:0]  retireDest;
    logic [procPkg::dataWidth-1:0]     retireData;

    logic [procPkg::instrWidth-1:0]    progMem [progDepth];

    // reference state
    logic [procPkg::dataWidth-1:0]     modelRegs [procPkg::regCount];
    logic [procPkg::dataWidth-1:0]     modelMem [procPkg::memDepth];
    logic                              memWritten [procPkg::memDepth];
    logic [procPkg::pcWidth-1:0]       modelPc = '0;
    logic [procPkg::regAddrWidth-1:0]  expDest [$];
    logic [procPkg::dataWidth-1:0]     expData [$];

    // kind of the instruction executed at the last edge
    logic                              pendNegImm     = 1'b0;
    logic                              pendStoredLoad = 1'b0;
    logic                              pendFreshLoad  = 1'b0;
    logic                              pendSilent     = 1'b0;

    int executedCount  = 0;
    int retireCount    = 0;
    int valueErrors    = 0;
    int protocolErrors = 0;
    int coverageErrors = 0;
    int negImmHits     = 0;   // sign-extended results with bit 31 set
    int storeLoadHits  = 0;
    int zeroLoads      = 0;
    int silentCount    = 0;   // nops and stores

    always #2 clk = ~clk;

    procCore dut (
        .clk         (clk),
        .clkreset    (clkreset),
        .instr       (instr),
        .fetchAddr   (fetchAddr),
        .retireValid (retireValid),
        .retireDest  (retireDest),
        .retireData  (retireData)
    );

    assign instr = progMem[fetchAddr];   // fetch answered in the same cycle

    ////////////////////////////////////////////////////////////////////////////
    // program generation
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [procPkg::instrWidth-1:0] buildImmInstr(
        input logic [3:0] funct, input logic [5:0] rs, input logic [5:0] rd,
        input logic [14:0] imm);
        procPkg::instr_t word;
        word         = '0;
        word.i.isImm = 1'b1;
        word.i.rs    = rs;
        word.i.rd    = rd;
        word.i.funct = funct;
        word.i.imm   = imm;
        return word;
    endfunction

    function automatic logic [procPkg::instrWidth-1:0] randomInstr();
        procPkg::instr_t word;
        logic [3:0]      code;
        logic            memOp;
        word = '0;
        case ($urandom_range(0, 5))
            0:       code = procPkg::opLoad;
            1:       code = procPkg::opStore;
            default: code = 4'($urandom_range(0, 15));   // unused codes included
        endcase
        memOp        = (code == procPkg::opLoad) || (code == procPkg::opStore);
        word.r.isImm = 1'($urandom_range(0, 1));
        word.r.rs    = 6'($urandom_range(0, 15));
        word.r.rd    = 6'($urandom_range(0, 15));
        word.r.funct = code;
        if (memOp && ($urandom_range(0, 1) == 1)) begin
            word.r.rs = '0;   // zero base so addresses collide
        end
        if (word.r.isImm) begin
            word.i.imm = memOp ? 15'($urandom_range(0, 7)) : 15'($urandom);
        end else begin
            word.r.rt = 6'($urandom_range(0, 15));
        end
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model, one instruction per edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic executeModel();
        procPkg::instr_t               word;
        logic [procPkg::dataWidth-1:0] opA;
        logic [procPkg::dataWidth-1:0] opB;
        logic [procPkg::dataWidth-1:0] sum;
        logic [procPkg::dataWidth-1:0] value;
        logic [6:0]                    memAddr;
        logic                          writes;
        word = progMem[modelPc];
        opA  = modelRegs[word.r.rs];
        if (word.r.isImm) begin
            opB = 32'($signed(word.i.imm));
        end else begin
            opB = modelRegs[word.r.rt];
        end
        sum            = opA + opB;
        memAddr        = sum[6:0];
        writes         = 1'b1;
        value          = '0;
        pendNegImm     = 1'b0;
        pendStoredLoad = 1'b0;
        pendFreshLoad  = 1'b0;
        pendSilent     = 1'b0;
        case (word.r.funct)
            procPkg::opAdd:    value = opA + opB;
            procPkg::opSub:    value = opA - opB;
            procPkg::opMove:   value = opA;
            procPkg::opAddInc: value = opA + opB + 32'd1;
            procPkg::opInc:    value = opA + 32'd1;
            procPkg::opDec:    value = opA - 32'd1;
            procPkg::opAnd:    value = opA & opB;
            procPkg::opOr:     value = opA | opB;
            procPkg::opXor:    value = opA ^ opB;
            procPkg::opNot:    value = ~opA;
            procPkg::opShl:    value = {opA[30:0], 1'b0};
            procPkg::opLoad: begin
                writes = word.r.isImm;   // register form does nothing
                value  = modelMem[memAddr];
                if (word.r.isImm && memWritten[memAddr]) begin
                    pendStoredLoad = 1'b1;
                end else if (word.r.isImm) begin
                    pendFreshLoad = 1'b1;
                end
            end
            procPkg::opStore: begin
                writes = 1'b0;
                if (word.r.isImm) begin
                    modelMem[memAddr]   = modelRegs[word.r.rd];
                    memWritten[memAddr] = 1'b1;
                end
            end
            default: writes = 1'b0;
        endcase
        if (!writes) begin
            pendSilent = 1'b1;
        end else if (word.r.rd != '0) begin
            modelRegs[word.r.rd] = value;
            expDest.push_back(word.r.rd);
            expData.push_back(value);
            if (word.r.isImm && word.i.imm[14] && value[31]) begin
                pendNegImm = 1'b1;
            end
        end
        executedCount++;
        modelPc = modelPc + 1'b1;
    endtask

    always @(posedge clk) begin
        if (clkreset) begin
            executeModel();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks, sampled at the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkCycle();
        logic [procPkg::regAddrWidth-1:0] wantDest;
        logic [procPkg::dataWidth-1:0]    wantData;
        assert (fetchAddr == modelPc) else begin
            valueErrors++;
            $display("Fail %0t: fetchAddr %0d, expected %0d", $time, fetchAddr, modelPc);
        end
        assert (retireValid == (expDest.size() != 0)) else begin
            protocolErrors++;
            $display("At %0t retireValid was %0b but the model expected %0d retires",
                     $time, retireValid, expDest.size());
        end
        if (pendSilent && !retireValid) begin
            silentCount++;
        end
        if (retireValid && (expDest.size() != 0)) begin
            wantDest = expDest.pop_front();
            wantData = expData.pop_front();
            assert (retireDest == wantDest) else begin
                valueErrors++;
                $display("Fail %0t: retireDest %0d, expected %0d", $time, retireDest, wantDest);
            end
            assert (retireData == wantData) else begin
                valueErrors++;
                $display("Fail %0t: retireData %h, expected %h", $time, retireData, wantData);
            end
            // only a correct retire counts toward coverage
            if ((retireDest == wantDest) && (retireData == wantData)) begin
                if (pendNegImm) begin
                    negImmHits++;
                end
                if (pendStoredLoad) begin
                    storeLoadHits++;
                end
                if (pendFreshLoad) begin
                    zeroLoads++;
                end
            end
            retireCount++;
        end
        expDest.delete();   // a missed retire is not matched later
        expData.delete();
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h0b95_1c63));
        clkreset = 1'b0;
        for (int idx = 0; idx < procPkg::regCount; idx++) begin
            modelRegs[idx] = '0;
        end
        for (int idx = 0; idx < procPkg::memDepth; idx++) begin
            modelMem[idx]   = '0;
            memWritten[idx] = 1'b0;
        end

        // directed head: fresh load, negative imm, store then load back
        progMem[0] = buildImmInstr(procPkg::opLoad, 6'd0, 6'd1, 15'd100);
        progMem[1] = buildImmInstr(procPkg::opAdd, 6'd0, 6'd2, 15'h7ffb);   // -5
        progMem[2] = buildImmInstr(procPkg::opStore, 6'd0, 6'd2, 15'd3);
        progMem[3] = buildImmInstr(procPkg::opLoad, 6'd0, 6'd3, 15'd3);
        for (int idx = 4; idx < progDepth; idx++) begin
            progMem[idx] = randomInstr();
        end

        repeat (8) @(posedge clk);
        clkreset <= 1'b1;

        cycles = 0;
        while ((executedCount < runLength) && (cycles < maxCycles)) begin
            @(negedge clk);
            checkCycle();
            cycles++;
        end

        if (executedCount < runLength) begin
            protocolErrors++;
            $display("Timeout: only %0d of %0d instructions executed",
                     executedCount, runLength);
        end else begin
            assert (negImmHits > 0) else begin
                coverageErrors++;
                $display("No negative immediate result was retired");
            end
            assert ((storeLoadHits > 0) && (zeroLoads > 0)) else begin
                coverageErrors++;
                $display("Loads did not cover both stored and never-written addresses");
            end
            assert (silentCount > 0) else begin
                coverageErrors++;
                $display("No store or nop was seen to pass without a retire");
            end
        end

        $display("errors: %0d value, %0d protocol, %0d coverage (%0d retires checked)",
                 valueErrors, protocolErrors, coverageErrors, retireCount);
        if ((valueErrors + protocolErrors + coverageErrors) == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
procPkg.sv
instrDecoder.sv
regFile.sv
aluUnit.sv
dataMem.sv
procCore.sv
procCore_checker.sv
procTb.sv

//--- runSim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module procTb -f files.f -o procSim \
    && ./obj_dir/procSim | awk '{ print } /SIMULATION PASSED/ { found = 1 } END { exit !found }' \
    && echo "runSim: run passed" \
    || { echo "runSim: run did not pass"; exit 1; }
